//--- source/agc_loop_pkg.sv
package agc_loop_pkg;

    ////////////////////////////////////////////////////////////
    // Loop constants
    ////////////////////////////////////////////////////////////
    localparam int INFO_WORDS = 6;   // Info words read per loop
    localparam int BOOT_DELAY = 31;  // Idle cycles before first write
    localparam int SCALE_W    = 17;
    localparam int OFFSET_W   = 16;

    localparam logic [SCALE_W-1:0]         START_SCALE  = 17'd1500;
    localparam logic signed [OFFSET_W-1:0] START_OFFSET = 16'sd0;

    localparam logic [SCALE_W-1:0]         SCALE_STEP  = 17'd30;
    localparam logic signed [OFFSET_W-1:0] OFFSET_STEP = 16'sd25;

    localparam logic [SCALE_W-1:0] SCALE_MIN = 17'd300;     // Scale falls only above this
    localparam logic [SCALE_W-1:0] SCALE_MAX = 17'd130000;  // Scale rises only below this

    localparam logic signed [OFFSET_W-1:0] OFFSET_LIMIT = 16'sd1000;
    localparam logic [31:0]                OFFSET_TOL   = 32'd5;  // Count difference for a move

    // Power measure is a slice of the accumulator in info word 1
    localparam int TIME_REDUCTION_BITS = 4;
    localparam int POWER_MSB           = 24;
    localparam int POWER_LSB           = 17 - TIME_REDUCTION_BITS;

    localparam int unsigned TARGET_POWER = 16;
    localparam int unsigned POWER_TOL    = 0;

    // Byte addresses in the AGC block
    localparam logic [7:0] CMD_ADDR    = 8'h00;
    localparam logic [7:0] SCALE_ADDR  = 8'h10;
    localparam logic [7:0] OFFSET_ADDR = 8'h14;

    localparam int CONTROL_PAGE_BIT = 6;  // Host page select, step constants when set

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////
    typedef enum logic [31:0] {
        CMD_START = 32'h0000_0001,
        CMD_RESET = 32'h0000_0004,
        CMD_LOAD  = 32'h0000_0300,
        CMD_APPLY = 32'h0000_0400
    } agc_cmd_e;

    typedef enum logic [3:0] {
        ST_BOOT,
        ST_RESET,
        ST_POLL_START,
        ST_WAIT_DONE,
        ST_READ_INFO,
        ST_CALC,
        ST_WRITE_SCALE,
        ST_WRITE_OFFSET,
        ST_LOAD,
        ST_APPLY
    } loop_state_e;

    typedef struct packed {
        logic        cyc;
        logic        we;
        logic [7:0]  adr;
        logic [31:0] dat;
    } bus_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } bus_rsp_t;

    // 0 status, 1 power, 2 above, 3 below, 4 scale, 5 offset
    typedef struct packed {
        logic [INFO_WORDS-1:0][31:0] word;
    } agc_info_t;

endpackage

//--- source/agc_scale_update.sv
module agc_scale_update (
    input  agc_loop_pkg::agc_info_t              info_i,
    output logic [agc_loop_pkg::SCALE_W-1:0]     next_scale_o
);

    logic [agc_loop_pkg::POWER_MSB-agc_loop_pkg::POWER_LSB:0] power;
    logic [agc_loop_pkg::SCALE_W-1:0]                         base;

    assign power = info_i.word[1][agc_loop_pkg::POWER_MSB:agc_loop_pkg::POWER_LSB];
    assign base  = info_i.word[4][agc_loop_pkg::SCALE_W-1:0];  // Scale now in use

    always_comb begin
        next_scale_o = base;  // In band, hold
        if (power > agc_loop_pkg::TARGET_POWER + agc_loop_pkg::POWER_TOL) begin
            // Too much power, back the gain off
            if (base > agc_loop_pkg::SCALE_MIN) begin
                next_scale_o = base - agc_loop_pkg::SCALE_STEP;
            end
        end else if (power < agc_loop_pkg::TARGET_POWER - agc_loop_pkg::POWER_TOL) begin
            if (base < agc_loop_pkg::SCALE_MAX) begin
                next_scale_o = base + agc_loop_pkg::SCALE_STEP;
            end
        end
    end

endmodule

//--- source/agc_offset_update.sv
module agc_offset_update (
    input  agc_loop_pkg::agc_info_t                  info_i,
    output logic signed [agc_loop_pkg::OFFSET_W-1:0] next_offset_o
);

    logic signed [agc_loop_pkg::OFFSET_W-1:0] base;
    logic [32:0]                              above;      // Extended so the tolerance cannot wrap
    logic [32:0]                              below;
    logic [32:0]                              tol;

    assign base  = info_i.word[5][agc_loop_pkg::OFFSET_W-1:0];
    assign above = {1'b0, info_i.word[2]};
    assign below = {1'b0, info_i.word[3]};
    assign tol   = {1'b0, agc_loop_pkg::OFFSET_TOL};

    always_comb begin
        next_offset_o = base;
        if (above > below + tol) begin
            // Samples sit high, pull the offset down
            if (base > -agc_loop_pkg::OFFSET_LIMIT) begin
                next_offset_o = base - agc_loop_pkg::OFFSET_STEP;
            end
        end else if (below > above + tol) begin
            if (base < agc_loop_pkg::OFFSET_LIMIT) begin
                next_offset_o = base + agc_loop_pkg::OFFSET_STEP;
            end
        end
    end

endmodule

//--- source/agc_loop_sequencer.sv
module agc_loop_sequencer (
    input  logic                                    aclk,
    input  logic                                    wb_rst_i,
    input  logic                                    agc_reset_i,
    input  agc_loop_pkg::bus_rsp_t                  agc_rsp_i,
    input  logic [agc_loop_pkg::SCALE_W-1:0]        next_scale_i,
    input  logic signed [agc_loop_pkg::OFFSET_W-1:0] next_offset_i,
    output agc_loop_pkg::bus_req_t                  agc_req_o,
    output agc_loop_pkg::agc_info_t                 info_o
);

    localparam int BOOT_W = $clog2(agc_loop_pkg::BOOT_DELAY + 1);

    typedef enum logic [1:0] {
        PH_SEND,   // Launch request of the current state
        PH_WAIT,   // Request on the bus until ack
        PH_CHECK   // Status word captured, test done bit
    } phase_e;

    agc_loop_pkg::loop_state_e                state;
    phase_e                                   phase;
    logic [BOOT_W-1:0]                        boot_cnt;
    logic [2:0]                               info_idx;
    logic                                     done_q;
    logic [agc_loop_pkg::SCALE_W-1:0]         held_scale;
    logic signed [agc_loop_pkg::OFFSET_W-1:0] held_offset;
    agc_loop_pkg::bus_req_t                   req_q;
    agc_loop_pkg::agc_info_t                  info_q;

    // Request word for each state of the loop
    function automatic agc_loop_pkg::bus_req_t build_req(
        input agc_loop_pkg::loop_state_e                st,
        input logic [2:0]                               idx,
        input logic [agc_loop_pkg::SCALE_W-1:0]         scale,
        input logic signed [agc_loop_pkg::OFFSET_W-1:0] offset
    );
        agc_loop_pkg::bus_req_t r;
        r.cyc = 1'b1;
        r.we  = 1'b1;
        r.adr = agc_loop_pkg::CMD_ADDR;
        r.dat = '0;
        case (st)
            agc_loop_pkg::ST_RESET:      r.dat = agc_loop_pkg::CMD_RESET;
            agc_loop_pkg::ST_POLL_START: r.dat = agc_loop_pkg::CMD_START;
            agc_loop_pkg::ST_WAIT_DONE:  r.we  = 1'b0;  // Status read
            agc_loop_pkg::ST_READ_INFO: begin
                r.we  = 1'b0;
                r.adr = {3'b000, idx, 2'b00};
            end
            agc_loop_pkg::ST_WRITE_SCALE: begin
                r.adr = agc_loop_pkg::SCALE_ADDR;
                r.dat = {{(32-agc_loop_pkg::SCALE_W){1'b0}}, scale};
            end
            agc_loop_pkg::ST_WRITE_OFFSET: begin
                r.adr = agc_loop_pkg::OFFSET_ADDR;
                r.dat = {{(32-agc_loop_pkg::OFFSET_W){offset[agc_loop_pkg::OFFSET_W-1]}}, offset};
            end
            agc_loop_pkg::ST_LOAD:       r.dat = agc_loop_pkg::CMD_LOAD;
            agc_loop_pkg::ST_APPLY:      r.dat = agc_loop_pkg::CMD_APPLY;
            default:                     r     = '0;
        endcase
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // Downstream control loop
    ////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (wb_rst_i || agc_reset_i) begin
            state          <= agc_loop_pkg::ST_BOOT;
            phase          <= PH_SEND;
            boot_cnt       <= BOOT_W'(agc_loop_pkg::BOOT_DELAY);
            info_idx       <= '0;
            done_q         <= 1'b0;
            held_scale     <= agc_loop_pkg::START_SCALE;
            held_offset    <= agc_loop_pkg::START_OFFSET;
            req_q          <= '0;
            info_q         <= '0;
            info_q.word[4] <= {{(32-agc_loop_pkg::SCALE_W){1'b0}}, agc_loop_pkg::START_SCALE};
            info_q.word[5] <= 32'(signed'(agc_loop_pkg::START_OFFSET));
        end else if (state == agc_loop_pkg::ST_BOOT) begin
            if (boot_cnt != '0) begin
                boot_cnt <= boot_cnt - 1'b1;
            end else begin  // First write uses the start values
                state <= agc_loop_pkg::ST_WRITE_SCALE;
                phase <= PH_WAIT;
                req_q <= build_req(agc_loop_pkg::ST_WRITE_SCALE, info_idx, held_scale,
                                   held_offset);
            end
        end else if (state == agc_loop_pkg::ST_CALC) begin
            held_scale  <= next_scale_i;
            held_offset <= next_offset_i;
            state       <= agc_loop_pkg::ST_WRITE_SCALE;
            phase       <= PH_WAIT;
            req_q       <= build_req(agc_loop_pkg::ST_WRITE_SCALE, info_idx, next_scale_i,
                                     next_offset_i);
        end else begin
            case (phase)
                PH_SEND: begin
                    req_q <= build_req(state, info_idx, held_scale, held_offset);
                    phase <= PH_WAIT;
                end
                PH_CHECK: begin
                    phase <= PH_WAIT;
                    if (done_q) begin  // Sample cycle finished
                        state    <= agc_loop_pkg::ST_READ_INFO;
                        info_idx <= '0;
                        req_q    <= build_req(agc_loop_pkg::ST_READ_INFO, 3'd0, held_scale,
                                              held_offset);
                    end else begin
                        req_q <= build_req(agc_loop_pkg::ST_WAIT_DONE, info_idx, held_scale,
                                           held_offset);
                    end
                end
                default: begin
                    if (agc_rsp_i.ack) begin
                        req_q <= '0;       // Drop cyc for one cycle
                        phase <= PH_SEND;
                        case (state)
                            agc_loop_pkg::ST_RESET:      state <= agc_loop_pkg::ST_POLL_START;
                            agc_loop_pkg::ST_POLL_START: state <= agc_loop_pkg::ST_WAIT_DONE;
                            agc_loop_pkg::ST_WAIT_DONE: begin
                                done_q <= agc_rsp_i.dat[1];
                                phase  <= PH_CHECK;
                            end
                            agc_loop_pkg::ST_READ_INFO: begin
                                info_q.word[info_idx] <= agc_rsp_i.dat;
                                if (info_idx == 3'(agc_loop_pkg::INFO_WORDS - 1)) begin
                                    state    <= agc_loop_pkg::ST_CALC;
                                    info_idx <= '0;
                                end else begin
                                    info_idx <= info_idx + 1'b1;
                                end
                            end
                            agc_loop_pkg::ST_WRITE_SCALE:  state <= agc_loop_pkg::ST_WRITE_OFFSET;
                            agc_loop_pkg::ST_WRITE_OFFSET: state <= agc_loop_pkg::ST_LOAD;
                            agc_loop_pkg::ST_LOAD:         state <= agc_loop_pkg::ST_APPLY;
                            agc_loop_pkg::ST_APPLY: begin
                                // Applied values become the current scale and offset
                                state          <= agc_loop_pkg::ST_RESET;
                                info_q.word[4] <= {{(32-agc_loop_pkg::SCALE_W){1'b0}}, held_scale};
                                info_q.word[5] <= 32'(held_offset);
                            end
                            default:                       state <= agc_loop_pkg::ST_BOOT;
                        endcase
                    end
                end
            endcase
        end
    end

    assign agc_req_o = req_q;
    assign info_o    = info_q;

endmodule

//--- source/agc_status_port.sv
module agc_status_port (
    input  logic                    aclk,
    input  logic                    wb_rst_i,
    input  agc_loop_pkg::bus_req_t  host_req_i,
    input  agc_loop_pkg::agc_info_t info_i,
    output agc_loop_pkg::bus_rsp_t  host_rsp_o
);

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_ACCESS,
        HS_ACK
    } host_state_e;

    host_state_e state;
    logic [3:0]  sel;     // Word index within a page
    logic [31:0] rd_mux;
    logic [31:0] rd_dat;

    assign sel = host_req_i.adr[5:2];

    always_comb begin
        rd_mux = '0;  // Writes and unmapped words read zero
        if (!host_req_i.we) begin
            if (host_req_i.adr[agc_loop_pkg::CONTROL_PAGE_BIT]) begin
                case (sel)
                    4'd0: rd_mux = {{(32-agc_loop_pkg::SCALE_W){1'b0}}, agc_loop_pkg::SCALE_STEP};
                    4'd1: rd_mux = 32'(agc_loop_pkg::OFFSET_STEP);
                    default: rd_mux = '0;
                endcase
            end else if (sel < 4'(agc_loop_pkg::INFO_WORDS)) begin
                rd_mux = info_i.word[sel[2:0]];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            state <= HS_IDLE;
        end else begin
            case (state)
                HS_IDLE:   if (host_req_i.cyc) state <= HS_ACCESS;
                HS_ACCESS: state <= HS_ACK;
                default:   state <= HS_IDLE;  // One ack cycle
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == HS_ACCESS) rd_dat <= rd_mux;
    end

    assign host_rsp_o = '{ack: (state == HS_ACK), dat: rd_dat};

endmodule

//--- source/agc_loop_top.sv
module agc_loop_top (
    input  logic                   aclk,
    input  logic                   wb_rst_i,
    input  logic                   agc_reset_i,
    input  agc_loop_pkg::bus_req_t host_req_i,
    input  agc_loop_pkg::bus_rsp_t agc_rsp_i,
    output agc_loop_pkg::bus_rsp_t host_rsp_o,
    output agc_loop_pkg::bus_req_t agc_req_o
);

    agc_loop_pkg::agc_info_t                  info;         // Latest info words
    logic [agc_loop_pkg::SCALE_W-1:0]         next_scale;
    logic signed [agc_loop_pkg::OFFSET_W-1:0] next_offset;

    agc_loop_sequencer i_sequencer (
        .aclk          (aclk),
        .wb_rst_i      (wb_rst_i),
        .agc_reset_i   (agc_reset_i),
        .agc_rsp_i     (agc_rsp_i),
        .next_scale_i  (next_scale),
        .next_offset_i (next_offset),
        .agc_req_o     (agc_req_o),
        .info_o        (info)
    );

    agc_status_port i_status_port (
        .aclk       (aclk),
        .wb_rst_i   (wb_rst_i),
        .host_req_i (host_req_i),
        .info_i     (info),
        .host_rsp_o (host_rsp_o)
    );

    // Both rules run side by side on the same info words
    agc_scale_update i_scale_update (
        .info_i       (info),
        .next_scale_o (next_scale)
    );

    agc_offset_update i_offset_update (
        .info_i        (info),
        .next_offset_o (next_offset)
    );

endmodule

//--- sim/agc_loop_assert.sv
module agc_loop_assert (
    input logic                   aclk,
    input logic                   wb_rst_i,
    input logic                   agc_reset_i,
    input agc_loop_pkg::bus_req_t agc_req_o,
    input agc_loop_pkg::bus_rsp_t agc_rsp_i,
    input agc_loop_pkg::bus_req_t host_req_i,
    input agc_loop_pkg::bus_rsp_t host_rsp_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // AGC master holds its request until the target acks
    cyc_held: assert property (@(posedge aclk) disable iff (wb_rst_i || agc_reset_i)
        agc_req_o.cyc && !agc_rsp_i.ack |=> agc_req_o.cyc)
        else $error("AGC cyc dropped before ack");

    req_stable: assert property (@(posedge aclk) disable iff (wb_rst_i || agc_reset_i)
        agc_req_o.cyc && !agc_rsp_i.ack |=>
            $stable(agc_req_o.adr) && $stable(agc_req_o.we) && $stable(agc_req_o.dat))
        else $error("AGC request changed while waiting for ack");

    host_ack_pulse: assert property (@(posedge aclk) disable iff (wb_rst_i)
        host_rsp_o.ack |=> !host_rsp_o.ack)
        else $error("Host ack longer than one cycle");

    host_ack_latency: assert property (@(posedge aclk) disable iff (wb_rst_i)
        $rose(host_req_i.cyc) |-> !host_rsp_o.ack ##1 !host_rsp_o.ack ##1 host_rsp_o.ack)
        else $error("Host ack not on the third edge");

endmodule

bind agc_loop_top agc_loop_assert i_assert (.*);

//--- sim/agc_loop_tb.sv
module agc_loop_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic                   aclk;
    logic                   wb_rst_i;
    logic                   agc_reset_i;
    agc_loop_pkg::bus_req_t host_req;
    agc_loop_pkg::bus_rsp_t host_rsp;
    agc_loop_pkg::bus_req_t agc_req;
    agc_loop_pkg::bus_rsp_t agc_rsp;

    agc_loop_top i_dut (
        .aclk        (aclk),
        .wb_rst_i    (wb_rst_i),
        .agc_reset_i (agc_reset_i),
        .host_req_i  (host_req),
        .agc_rsp_i   (agc_rsp),
        .host_rsp_o  (host_rsp),
        .agc_req_o   (agc_req)
    );

    logic [31:0]            seed = 32'd34;
    int                     err_cnt = 0;
    agc_loop_pkg::bus_req_t txn_q[$];      // Transactions seen by the AGC block model
    agc_loop_pkg::bus_req_t cap_req;
    logic [31:0]            cap_dat;
    logic [31:0]            info_w [6];    // Info words the model serves this loop
    logic [31:0]            exp_words [6]; // Expected host view of the info words
    logic [31:0]            last_scale;
    logic [31:0]            last_offset;
    logic [31:0]            applied_scale;
    logic [31:0]            applied_offset;
    logic [31:0]            stop_cmd;
    logic                   hold;
    logic                   ack_pend;
    logic                   info_mode;
    int                     info_cnt;
    int                     polls_left;
    int                     gen_polls;
    int                     wait_cnt;

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {16'h0, seed[31:16]};
    endfunction

    function automatic logic [31:0] rand32();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi[15:0], lo[15:0]};
    endfunction

    function automatic agc_loop_pkg::bus_req_t mk_req(logic we, logic [7:0] adr, logic [31:0] dat);
        return '{cyc: 1'b1, we: we, adr: adr, dat: dat};
    endfunction

    // Scale rule: step against the power error, hold at the cutoffs
    function automatic logic [31:0] ref_scale(logic [31:0] pw_word, logic [31:0] base_word);
        int unsigned p;
        int unsigned b;
        p = (pw_word >> 13) & 32'hFFF;
        b = base_word & 32'h1FFFF;
        if (p > 16 && b > 300) b = b - 30;
        else if (p < 16 && b < 130000) b = b + 30;
        return b;
    endfunction

    function automatic logic [31:0] ref_offset(logic [31:0] above, logic [31:0] below,
                                               logic [31:0] off_word);
        int     b;
        longint a;
        longint c;
        b = int'(signed'(off_word[15:0]));
        a = longint'(above);
        c = longint'(below);
        if (a > c + 5 && b > -1000) b = b - 25;
        else if (c > a + 5 && b < 1000) b = b + 25;
        return b;
    endfunction

    task automatic fail_now(string msg);
        err_cnt++;
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_req(string name, agc_loop_pkg::bus_req_t got,
                             agc_loop_pkg::bus_req_t exp);
        if (got !== exp)
            fail_now($sformatf("Mismatch agc_req_o (%s): got %h expected %h", name, got, exp));
    endtask

    task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
            fail_now($sformatf("Mismatch host_rsp_o.dat (%s): got %h expected %h",
                               name, got, exp));
    endtask

    ////////////////////////////////////////////////////////////
    // AGC block model
    ////////////////////////////////////////////////////////////
    task automatic gen_info();
        int unsigned pw;
        int          v;
        int          d;
        case (lcg_next() % 4)  // Near the cutoffs half of the time
            0: info_w[4] = applied_scale;
            1: info_w[4] = 290 + lcg_next() % 20;
            2: info_w[4] = 129990 + lcg_next() % 20;
            default: info_w[4] = lcg_next() % 131072;
        endcase
        case (lcg_next() % 3)
            0: pw = 16;
            1: pw = lcg_next() % 16;
            default: pw = 17 + lcg_next() % 4079;
        endcase
        // Steer the power toward the cutoff the scale sits next to
        if (info_w[4] < 310) pw = 17 + lcg_next() % 4079;
        else if (info_w[4] >= 129990) pw = lcg_next() % 16;
        info_w[0] = rand32();
        info_w[1] = (rand32() & 32'hFE00_0000) | (pw << 13) | (lcg_next() & 32'h1FFF);
        case (lcg_next() % 4)
            0: v = int'(signed'(applied_offset[15:0]));
            1: v = -1010 + int'(lcg_next() % 20);
            2: v = 990 + int'(lcg_next() % 20);
            default: v = int'(lcg_next() % 4001) - 2000;
        endcase
        d = int'(lcg_next() % 21) - 10;
        if (v <= -990) d = -6 - int'(lcg_next() % 5);  // Counts push toward the limit
        else if (v >= 990) d = 6 + int'(lcg_next() % 5);
        info_w[2] = 20 + lcg_next() % 1000;
        info_w[3] = info_w[2] + d;
        info_w[5] = v;
    endtask

    function automatic logic [31:0] read_data(agc_loop_pkg::bus_req_t r);
        if (info_mode) return info_w[r.adr[4:2]];
        return (polls_left == 0) ? 32'h2 : 32'h0;  // Bit 1 flags done
    endfunction

    task automatic handle_txn(agc_loop_pkg::bus_req_t r);
        if (r.we) begin
            if (r.adr == agc_loop_pkg::SCALE_ADDR) last_scale = r.dat;
            if (r.adr == agc_loop_pkg::OFFSET_ADDR) last_offset = r.dat;
            if (r.adr == agc_loop_pkg::CMD_ADDR && r.dat == agc_loop_pkg::CMD_START) begin
                gen_info();
                gen_polls  = lcg_next() % 4;
                polls_left = gen_polls;
            end
            if (r.adr == agc_loop_pkg::CMD_ADDR && r.dat == agc_loop_pkg::CMD_APPLY) begin
                applied_scale  = last_scale;
                applied_offset = last_offset;
            end
            if (r.adr == agc_loop_pkg::CMD_ADDR && r.dat == stop_cmd) hold = 1'b1;
        end else if (!info_mode) begin
            if (polls_left == 0) begin
                info_mode = 1'b1;
                info_cnt  = 0;
            end else begin
                polls_left--;
            end
        end else begin
            info_cnt++;
            if (info_cnt == 6) info_mode = 1'b0;
        end
        txn_q.push_back(r);
    endtask

    initial begin
        forever begin
            @(posedge aclk);
            #2;
            if (ack_pend) begin
                agc_rsp.ack = 1'b0;
                ack_pend    = 1'b0;
                handle_txn(cap_req);
            end else if (agc_req.cyc && !hold && !agc_reset_i) begin
                if (wait_cnt == 0) begin  // Back-pressure done, ack now
                    cap_req  = agc_req;
                    cap_dat  = read_data(agc_req);
                    agc_rsp  = '{ack: 1'b1, dat: cap_dat};
                    ack_pend = 1'b1;
                    wait_cnt = lcg_next() % 4;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////
    task automatic pop_txn(output agc_loop_pkg::bus_req_t r);
        int t;
        t = 0;
        while (txn_q.size() == 0) begin
            @(posedge aclk);
            t++;
            if (t > 200) fail_now("Timeout waiting for an AGC bus transaction");
        end
        r = txn_q.pop_front();
    endtask

    task automatic expect_txn(string name, agc_loop_pkg::bus_req_t exp);
        agc_loop_pkg::bus_req_t r;
        pop_txn(r);
        check_req(name, r, exp);
    endtask

    task automatic wait_hold();
        int t;
        t = 0;
        while (!hold) begin
            @(posedge aclk);
            t++;
            if (t > 100) fail_now("Timeout waiting for the model to stall the loop");
        end
    endtask

    task automatic host_access(logic [7:0] adr, logic we, output logic [31:0] data);
        int t;
        t = 0;
        @(posedge aclk);
        #2;
        host_req = '{cyc: 1'b1, we: we, adr: adr, dat: 32'h0};
        do begin
            @(posedge aclk);
            #2;
            t++;
            if (t > 8) fail_now("Timeout waiting for host ack");
        end while (!host_rsp.ack);
        data         = host_rsp.dat;
        host_req.cyc = 1'b0;
        @(posedge aclk);
        #2;
        if (host_rsp.ack) fail_now("Host ack lasted more than one cycle");
    endtask

    task automatic check_host();
        logic [31:0] d;
        for (int i = 0; i < 6; i++) begin
            host_access(8'(i * 4), 1'b0, d);
            check_word($sformatf("host info word %0d", i), d, exp_words[i]);
        end
        host_access(8'h40, 1'b0, d);
        check_word("host scale step", d, 32'd30);
        host_access(8'h44, 1'b0, d);
        check_word("host offset step", d, 32'd25);
        host_access(8'h48, 1'b0, d);
        check_word("host unmapped control word", d, 32'h0);
        host_access(8'h18, 1'b0, d);
        check_word("host unmapped info word", d, 32'h0);
        host_access(8'h04, 1'b1, d);
        check_word("host write data", d, 32'h0);
    endtask

    // Start values, load and apply, then a host check while stalled
    task automatic expect_boot();
        expect_txn("boot scale write", mk_req(1'b1, agc_loop_pkg::SCALE_ADDR, 32'd1500));
        expect_txn("boot offset write", mk_req(1'b1, agc_loop_pkg::OFFSET_ADDR, 32'd0));
        expect_txn("boot load", mk_req(1'b1, 8'h00, 32'h300));
        expect_txn("boot apply", mk_req(1'b1, 8'h00, 32'h400));
        wait_hold();
        exp_words = '{0, 0, 0, 0, 1500, 0};
        check_host();
        hold = 1'b0;
    endtask

    initial begin
        logic [31:0] s_exp;
        logic [31:0] o_exp;
        wb_rst_i       = 1'b1;
        agc_reset_i    = 1'b0;
        host_req       = '0;
        agc_rsp        = '0;
        hold           = 1'b0;
        ack_pend       = 1'b0;
        info_mode      = 1'b0;
        info_cnt       = 0;
        polls_left     = 0;
        gen_polls      = 0;
        wait_cnt       = 0;
        stop_cmd       = 32'h400;
        applied_scale  = 32'd1500;
        applied_offset = 32'd0;
        repeat (3) @(posedge aclk);
        #2;
        wb_rst_i = 1'b0;
        if (agc_req.cyc || host_rsp.ack) fail_now("AGC cyc or host ack high after reset");
        expect_boot();
        for (int loop = 0; loop < 40; loop++) begin
            if (loop == 20) stop_cmd = 32'h1;  // Stall after CMD_START
            expect_txn("reset command", mk_req(1'b1, 8'h00, 32'h4));
            expect_txn("start command", mk_req(1'b1, 8'h00, 32'h1));
            if (loop == 20) begin
                wait_hold();
                @(posedge aclk);
                #2;
                agc_reset_i = 1'b1;
                @(posedge aclk);
                #2;
                agc_reset_i    = 1'b0;
                applied_scale  = 32'd1500;
                applied_offset = 32'd0;
                info_mode      = 1'b0;
                stop_cmd       = 32'h400;
                hold           = 1'b0;
                expect_boot();
                continue;
            end
            for (int p = 0; p <= gen_polls; p++)
                expect_txn("status poll", mk_req(1'b0, 8'h00, 32'h0));
            for (int i = 0; i < 6; i++)
                expect_txn($sformatf("info read %0d", i), mk_req(1'b0, 8'(i * 4), 32'h0));
            s_exp = ref_scale(info_w[1], info_w[4]);
            o_exp = ref_offset(info_w[2], info_w[3], info_w[5]);
            expect_txn("scale write", mk_req(1'b1, agc_loop_pkg::SCALE_ADDR, s_exp));
            expect_txn("offset write", mk_req(1'b1, agc_loop_pkg::OFFSET_ADDR, o_exp));
            expect_txn("load command", mk_req(1'b1, 8'h00, 32'h300));
            expect_txn("apply command", mk_req(1'b1, 8'h00, 32'h400));
            wait_hold();
            exp_words = '{info_w[0], info_w[1], info_w[2], info_w[3], s_exp, o_exp};
            check_host();
            hold = 1'b0;
        end
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
source/agc_loop_pkg.sv
source/agc_scale_update.sv
source/agc_offset_update.sv
source/agc_loop_sequencer.sv
source/agc_status_port.sv
source/agc_loop_top.sv
sim/agc_loop_assert.sv
sim/agc_loop_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the AGC loop testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module agc_loop_tb \
    -o agc_loop_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/agc_loop_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0
